// ==== peak_pkg.sv ====
/*
  Shared sizes, vector types and the controller state encoding for the
  four-channel peak capture block. Modules import it inside their body and
  use scoped names in their port lists.
*/

package peak_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  localparam int num_chan     = 4;
  localparam int chan_w       = 16;
  localparam int burst_len    = 16;
  localparam int win_len      = 8;
  localparam int thresh_shift = 3;
  localparam int idx_w        = 4;
  localparam int sum_w        = chan_w + 3;

  //////////////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic signed [chan_w-1:0] chan_t;
  // unsigned magnitude that saturates at mag_max
  typedef logic [chan_w-1:0] mag_t;
  typedef logic [sum_w-1:0] sum_t;
  typedef logic [idx_w-1:0] idx_t;

  // one input word with ch0 in the low bits
  typedef struct packed {
    chan_t ch3;
    chan_t ch2;
    chan_t ch1;
    chan_t ch0;
  } sample_t;

  typedef enum logic {
    st_idle,
    st_replay
  } ctrl_state_t;

  // magnitude limits
  localparam chan_t chan_min = {1'b1, {(chan_w-1){1'b0}}};
  localparam mag_t  mag_max  = {1'b0, {(chan_w-1){1'b1}}};

endpackage

// ==== peak_window.sv ====
/*
  Per-channel peak detector. Takes the saturated magnitude of each accepted
  sample, keeps a short magnitude history and an eight-beat running sum, and
  raises peak for one cycle when the delayed magnitude beats the threshold.
*/

`timescale 1ns/1ps

module peak_window (
  input  logic            clk,
  input  logic            rst,
  input  logic            beat,
  input  peak_pkg::chan_t sample,
  output logic            peak
);

  import peak_pkg::*;

  mag_t mag;
  mag_t hist [burst_len];
  sum_t sum_q;
  sum_t sum_next;
  sum_t thresh;
  logic rule;

  // magnitude with saturation of the most negative value
  always_comb begin
    if (sample == chan_min) begin
      mag = mag_max;
    end else if (sample[chan_w-1]) begin
      mag = mag_t'(-sample);
    end else begin
      mag = mag_t'(sample);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // window sum and threshold
  //////////////////////////////////////////////////////////////////////

  // hist[win_len-1] drops out of the window on this beat, and it is
  // also the entry eight beats before the new one
  assign sum_next = sum_q + sum_t'(mag) - sum_t'(hist[win_len-1]);
  assign thresh   = (sum_next >> thresh_shift) << thresh_shift;
  assign rule     = sum_t'(hist[win_len-1]) > thresh;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < burst_len; i++) begin
        hist[i] <= '0;
      end
      sum_q <= '0;
      peak  <= 1'b0;
    end else begin
      peak <= beat & rule;
      if (beat) begin
        hist[0] <= mag;
        for (int i = 1; i < burst_len; i++) begin
          hist[i] <= hist[i-1];
        end
        sum_q <= sum_next;
      end
    end
  end

endmodule

// ==== capture_buffer.sv ====
/*
  History of the sixteen newest accepted raw words. Shifts on each beat so
  index 0 is always the newest word; the read port is combinational.
*/

`timescale 1ns/1ps

module capture_buffer (
  input  logic              clk,
  input  logic              rst,
  input  logic              beat,
  input  peak_pkg::sample_t din,
  input  peak_pkg::idx_t    rd_idx,
  output peak_pkg::sample_t dout
);

  import peak_pkg::*;

  sample_t mem [burst_len];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < burst_len; i++) begin
        mem[i] <= '0;
      end
    end else if (beat) begin
      mem[0] <= din;
      for (int i = 1; i < burst_len; i++) begin
        mem[i] <= mem[i-1];
      end
    end
  end

  // word rd_idx beats old
  assign dout = mem[rd_idx];

endmodule

// ==== burst_output.sv ====
/*
  One-word output register for the replay burst. Asks the controller for the
  next word through take whenever the register is empty or draining, and
  holds its word and last marker under back-pressure.
*/

`timescale 1ns/1ps

module burst_output (
  input  logic              clk,
  input  logic              rst,
  input  logic              replay,
  input  peak_pkg::idx_t    rd_idx,
  input  peak_pkg::sample_t rd_data,
  output logic              take,
  output logic              out_valid,
  input  logic              out_ready,
  output peak_pkg::sample_t out_data,
  output logic              out_last
);

  // register free this cycle
  assign take = replay & (~out_valid | out_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else if (take) begin
      out_valid <= 1'b1;
      out_last  <= (rd_idx == '0);
    end else if (out_ready) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_data <= rd_data;
    end
  end

  // stalled word must not change
  a_hold_stable: assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> $stable(out_data) && $stable(out_last)
  );

endmodule

// ==== capture_ctrl.sv ====
/*
  Control FSM for the capture block. In idle it accepts input until a window
  flags a peak, then replays the buffer from index 15 down to 0, one word per
  take from the output register, and returns to idle.
*/

`timescale 1ns/1ps

module capture_ctrl (
  input  logic           clk,
  input  logic           rst,
  input  logic           peak_any,
  input  logic           take,
  input  logic           in_valid,
  output logic           in_ready,
  output logic           beat,
  output logic           replay,
  output peak_pkg::idx_t rd_idx
);

  import peak_pkg::*;

  ctrl_state_t state;

  //////////////////////////////////////////////////////////////////////
  // input handshake
  //////////////////////////////////////////////////////////////////////

  // stop taking input as soon as a flag shows up
  assign in_ready = (state == st_idle) & ~peak_any;
  assign beat     = in_valid & in_ready;
  assign replay   = (state == st_replay);

  //////////////////////////////////////////////////////////////////////
  // state and read index
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= st_idle;
      rd_idx <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (peak_any) begin
            state  <= st_replay;
            rd_idx <= idx_t'(burst_len - 1);
          end
        end
        st_replay: begin
          if (take) begin
            // oldest word first and index 0 last
            if (rd_idx == '0) begin
              state <= st_idle;
            end else begin
              rd_idx <= rd_idx - 1'b1;
            end
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // input reopens the cycle after the last take
  a_ready_after_burst: assert property (
    @(posedge clk) disable iff (rst)
    state == st_replay && take && rd_idx == '0 |=> in_ready
  );

  // output stage only pulls words during replay
  a_take_in_replay: assert property (
    @(posedge clk) disable iff (rst)
    take |-> state == st_replay
  );

endmodule

// ==== peak_capture_top.sv ====
/*
  Four-channel peak capture top level. Accepts 64-bit sample words, runs a
  peak window per channel, and on any peak replays the sixteen newest words
  as one burst with a last marker on the newest word.
*/

`timescale 1ns/1ps

module peak_capture_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  output logic              in_ready,
  input  peak_pkg::sample_t in_data,
  output logic              out_valid,
  input  logic              out_ready,
  output peak_pkg::sample_t out_data,
  output logic              out_last
);

  import peak_pkg::*;

  logic [num_chan-1:0] peak_bits;
  logic                peak_any;
  logic                beat;
  logic                replay;
  logic                take;
  idx_t                rd_idx;
  sample_t             rd_data;

  //////////////////////////////////////////////////////////////////////
  // per-channel windows
  //////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < num_chan; g++) begin : g_win
    peak_window i_win (
      .clk    (clk),
      .rst    (rst),
      .beat   (beat),
      .sample (chan_t'(in_data[g*chan_w +: chan_w])),
      .peak   (peak_bits[g])
    );
  end

  assign peak_any = |peak_bits;

  //////////////////////////////////////////////////////////////////////
  // buffer, control and output stage
  //////////////////////////////////////////////////////////////////////

  capture_buffer i_buf (
    .clk    (clk),
    .rst    (rst),
    .beat   (beat),
    .din    (in_data),
    .rd_idx (rd_idx),
    .dout   (rd_data)
  );

  capture_ctrl i_ctrl (
    .clk      (clk),
    .rst      (rst),
    .peak_any (peak_any),
    .take     (take),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .beat     (beat),
    .replay   (replay),
    .rd_idx   (rd_idx)
  );

  burst_output i_out (
    .clk       (clk),
    .rst       (rst),
    .replay    (replay),
    .rd_idx    (rd_idx),
    .rd_data   (rd_data),
    .take      (take),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_last  (out_last)
  );

endmodule

// ==== tb_peak_capture.sv ====
/*
  Testbench for the peak capture top level. Applies a table of sample steps,
  keeps its own model of accepted beats and of the peak rule, and checks
  every burst word, the last marker, stall hold and input back-pressure.
*/

`timescale 1ns/1ps

module tb_peak_capture;

  import peak_pkg::*;

  // one table row with four channel values, repeat count and ready mode
  typedef struct packed {
    logic [chan_w-1:0] c0;
    logic [chan_w-1:0] c1;
    logic [chan_w-1:0] c2;
    logic [chan_w-1:0] c3;
    logic [15:0]       count;
    logic              rnd_ready;
  } step_t;

  localparam logic [31:0] seed = 32'hc112_64c5;
  localparam int bursts_exp = 6;

  logic        clk;
  logic        rst;
  logic        in_valid;
  logic        in_ready;
  sample_t     in_data;
  logic        out_valid;
  logic        out_ready;
  sample_t     out_data;
  logic        out_last;

  step_t       steps [$];
  sample_t     words [burst_len];
  sample_t     exp_data [$];
  logic        exp_last [$];
  logic [31:0] noise_rng;
  logic [31:0] ready_rng;
  logic        ready_mode;
  logic        stall_q;
  sample_t     held_data;
  logic        held_last;
  int          errors;
  int          cycles;
  int          limit;
  int          bursts;

  peak_capture_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_last  (out_last)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // saturated magnitude of channel c
  function automatic int magnitude(input sample_t w, input int c);
    logic signed [chan_w-1:0] v;
    v = w[c*chan_w +: chan_w];
    if (v == {1'b1, {(chan_w-1){1'b0}}}) begin
      return 2**(chan_w-1) - 1;
    end
    return (v < 0) ? -int'(v) : int'(v);
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expv);
    if (got !== expv) begin
      $display("Fail %s: got %h expected %h at %0t", name, got, expv, $time);
      errors++;
    end
  endtask

  task automatic add_step(input int c0, input int c1, input int c2, input int c3,
                          input int count, input logic rnd);
    steps.push_back(step_t'({c0[15:0], c1[15:0], c2[15:0], c3[15:0], count[15:0], rnd}));
  endtask

  // model of one accepted beat that queues a burst when the rule holds
  task automatic accept_word(input sample_t w);
    int   sum;
    logic hit;
    hit = 1'b0;
    for (int k = burst_len - 1; k > 0; k--) begin
      words[k] = words[k-1];
    end
    words[0] = w;
    for (int c = 0; c < num_chan; c++) begin
      sum = 0;
      for (int k = 0; k < 8; k++) begin
        sum += magnitude(words[k], c);
      end
      if (magnitude(words[8], c) > (sum / 8) * 8) begin
        hit = 1'b1;
      end
    end
    if (hit) begin
      for (int k = burst_len - 1; k >= 0; k--) begin
        exp_data.push_back(words[k]);
        exp_last.push_back(k == 0);
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////
  // output ready and monitor
  ////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic mode;
    mode = ready_mode;
    #1;
    ready_rng = xorshift(ready_rng);
    out_ready = mode ? ready_rng[9] : 1'b1;
  end

  // sampled at the falling edge where everything is settled
  always @(negedge clk) begin
    if (!rst) begin
      if (stall_q) begin
        check_value("out_valid (held)", out_valid, 1);
        check_value("out_data (held)", out_data, held_data);
        check_value("out_last (held)", out_last, held_last);
      end
      stall_q   = out_valid && !out_ready;
      held_data = out_data;
      held_last = out_last;
      if (exp_data.size() > 1) begin
        check_value("in_ready", in_ready, 0);
      end
      if (out_valid && out_ready) begin
        if (exp_data.size() == 0) begin
          $display("unexpected output word, no burst was due at %0t", $time);
          errors++;
        end else begin
          check_value("out_data", out_data, exp_data.pop_front());
          check_value("out_last", out_last, exp_last.pop_front());
        end
        if (out_last) begin
          bursts++;
        end
      end
      if (in_valid && in_ready) begin
        accept_word(in_data);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout, run did not finish within %0d cycles", limit);
      $display("errors: %0d, bursts: %0d", errors, bursts);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////

  initial begin
    logic acc;
    int   total;
    rst = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    out_ready = 1'b0;
    ready_mode = 1'b0;
    noise_rng = seed;
    ready_rng = xorshift(seed);
    stall_q = 1'b0;
    errors = 0;
    cycles = 0;
    bursts = 0;
    total = 0;
    for (int k = 0; k < burst_len; k++) begin
      words[k] = '0;
    end
    add_step(10, 40, 40, -10, 12, 0);
    add_step(300, 40, 40, -10, 1, 0);
    add_step(10, 40, 40, -10, 12, 0);
    // full scale eight beats before the most negative value
    // triggers only when that value saturates to 32767
    add_step(10, 40, 40, 32767, 1, 0);
    add_step(10, 40, 40, 0, 7, 0);
    add_step(10, 40, 40, -32768, 1, 0);
    add_step(10, 40, 40, -10, 12, 0);
    // just over and exactly at the threshold of 80
    add_step(81, 40, 40, -10, 1, 0);
    add_step(10, 40, 40, -10, 12, 0);
    add_step(80, 40, 40, -10, 1, 0);
    add_step(10, 40, 40, -10, 12, 0);
    add_step(10, 40, 40, 500, 1, 1);
    add_step(10, 40, 40, -10, 12, 1);
    add_step(-1000, 40, 40, -10, 1, 1);
    add_step(10, 40, 40, -10, 12, 1);
    foreach (steps[i]) begin
      total += steps[i].count;
    end
    limit = total * 4 + 200;
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    check_value("in_ready", in_ready, 1);
    check_value("out_valid", out_valid, 0);
    foreach (steps[i]) begin
      ready_mode = steps[i].rnd_ready;
      for (int n = 0; n < steps[i].count; n++) begin
        noise_rng = xorshift(noise_rng);
        in_data.ch0 = steps[i].c0;
        in_data.ch1 = steps[i].c1 + noise_rng[1:0];
        in_data.ch2 = steps[i].c2 + noise_rng[3:2];
        in_data.ch3 = steps[i].c3;
        in_valid = 1'b1;
        // word held until accepted
        do begin
          @(negedge clk);
          acc = in_ready;
          @(posedge clk);
          #1;
        end while (!acc);
      end
    end
    in_valid = 1'b0;
    ready_mode = 1'b0;
    while (exp_data.size() != 0 || out_valid) begin
      @(negedge clk);
    end
    repeat (4) @(posedge clk);
    check_value("burst count", bursts, bursts_exp);
    $display("errors: %0d, bursts: %0d", errors, bursts);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
peak_pkg.sv
peak_window.sv
capture_buffer.sv
burst_output.sv
capture_ctrl.sv
peak_capture_top.sv
tb_peak_capture.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and decide the result from the simulation log
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_peak_capture -o tb_peak_capture > build.log 2>&1 \
  && ./obj_dir/tb_peak_capture > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "no result in log"; exit 1; }
exit 0
